//--- include/event_core_cfg.svh
`ifndef EVENT_CORE_CFG_SVH
`define EVENT_CORE_CFG_SVH

// Field size.
`define OBJ_LIMIT 8
`define R_LIMIT   15   // Rim radius, also the laser's last step.
`define ANGLE_MAX 359

// Half-width of the laser cone, in degrees.
`define LSR_WIDTH 10

// Frame counter bits that pace the game.
`define MOVE_BIT  7
`define ANIM_BIT  4
`define DIE_BIT   2
`define SWING_BIT 6

`define SCORE_W   16

`endif

//--- hdl/object_pkg.sv
package object_pkg;

    typedef enum logic [1:0] {
        ST_INACTIVE = 2'd0,
        ST_ACTIVE   = 2'd1,
        ST_DYING    = 2'd2
    } alien_state_t;

    // Movement pattern.
    typedef enum logic [1:0] {
        KIND_0 = 2'd0,  // Swings with the counter.
        KIND_1 = 2'd1,  // Swings against type 0.
        KIND_2 = 2'd2,  // Fast walk, rising angle.
        KIND_3 = 2'd3   // Fast walk, falling angle.
    } alien_kind_t;

    typedef struct packed {
        logic [3:0]   r;          // Distance from the player.
        logic [8:0]   theta;      // Degrees, 0 to 359.
        logic [3:0]   hp;
        alien_state_t state;
        alien_kind_t  kind;
        logic [1:0]   frame_num;  // Animation frame.
        logic [1:0]   spare;
    } alien_t;

    // Slot number, also one entry of the sorter's permutation.
    typedef logic [2:0] slot_idx_t;

endpackage

//--- hdl/player_pkg.sv
package player_pkg;

    // Firing directions, deg = dir * 90 + 45.
    typedef enum logic [1:0] {
        DIR_45  = 2'd0,
        DIR_135 = 2'd1,
        DIR_225 = 2'd2,
        DIR_315 = 2'd3
    } dir_t;

    typedef struct packed {
        logic       active;
        logic [3:0] r;
        logic [8:0] deg;
    } laser_t;

    typedef struct packed {
        logic                  valid;
        object_pkg::slot_idx_t slot;
        logic                  kill;   // Last hit point gone.
    } hit_t;

    typedef struct packed {
        logic advance;  // Frame steps this cycle.
        logic move;
        logic anim;
        logic die;
        logic swing;    // Direction for types 0 and 1.
        logic odd;      // Double step for types 2 and 3.
    } frame_tick_t;

endpackage

//--- hdl/frame_control.sv
`timescale 1ns/100ps
`include "event_core_cfg.svh"

module frame_control (
    input  logic                    clk_frame,
    input  logic                    rst,
    input  logic                    en,
    output player_pkg::frame_tick_t tick
);

    logic [15:0] frame_cnt;
    logic [2:0]  watch_bits;  // {move, anim, die}.
    logic [2:0]  watch_prev;
    logic [2:0]  watch_rise;

    assign watch_bits = {frame_cnt[`MOVE_BIT], frame_cnt[`ANIM_BIT], frame_cnt[`DIE_BIT]};

    // History moves with the counter and an edge waits for the next enabled frame.
    always_ff @(posedge clk_frame or posedge rst) begin
        if (rst) begin
            frame_cnt  <= '0;
            watch_prev <= '0;
        end else if (en) begin
            frame_cnt  <= frame_cnt + 16'd1;
            watch_prev <= watch_bits;
        end
    end

    assign watch_rise = watch_bits & ~watch_prev & {3{en}};

    always_comb begin
        tick.advance = en;
        tick.move    = watch_rise[2];
        tick.anim    = watch_rise[1];
        tick.die     = watch_rise[0];
        tick.swing   = frame_cnt[`SWING_BIT];
        tick.odd     = frame_cnt[0];
    end

    //////////////////////////////
    // Strobes only mark frames in which the counter steps.
    assert property (@(posedge clk_frame) disable iff (rst)
        (tick.move || tick.anim || tick.die) |=> frame_cnt == $past(frame_cnt) + 16'd1);

    // A move strobe is consumed by exactly one frame.
    assert property (@(posedge clk_frame) disable iff (rst)
        tick.move |=> !tick.move);

    // Same for the death animation.
    assert property (@(posedge clk_frame) disable iff (rst)
        tick.die |=> !tick.die);

endmodule

//--- hdl/alien_table.sv
`timescale 1ns/100ps
`include "event_core_cfg.svh"

module alien_table (
    input  logic                    clk_frame,
    input  logic                    rst,
    input  player_pkg::frame_tick_t tick,
    input  logic                    spawn_object,
    input  object_pkg::alien_t      spawn_data,
    input  player_pkg::hit_t        hit,
    output object_pkg::alien_t      slots [`OBJ_LIMIT],
    output logic                    all_clear,
    output logic                    game_over,
    output logic [3:0]              object_count
);

    import object_pkg::*;

    localparam alien_t IDLE_SLOT = '{
        r:         4'(`R_LIMIT),
        theta:     '0,
        hp:        '0,
        state:     ST_INACTIVE,
        kind:      KIND_0,
        frame_num: '0,
        spare:     '0
    };

    alien_t    slots_next [`OBJ_LIMIT];
    alien_t    spawn_rec;
    logic      free_found;
    slot_idx_t free_idx;

    // One angular step with wrap at the full circle.
    function automatic logic [8:0] theta_step(input logic [8:0] theta, input logic up,
                                              input logic [1:0] step);
        logic [9:0] sum;
        sum = 10'(theta) + 10'(step);
        if (up) begin
            theta_step = (sum > `ANGLE_MAX) ? 9'(sum - (`ANGLE_MAX + 1)) : sum[8:0];
        end else if (theta < 9'(step)) begin
            theta_step = 9'(theta + (`ANGLE_MAX + 1) - step);
        end else begin
            theta_step = theta - 9'(step);
        end
    endfunction

    //////////////////////////////
    // Spawn target.
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = 0; i < `OBJ_LIMIT; i++) begin
            if (!free_found && slots[i].state == ST_INACTIVE) begin
                free_found = 1'b1;
                free_idx   = slot_idx_t'(i);
            end
        end
    end

    always_comb begin
        spawn_rec       = spawn_data;
        spawn_rec.state = ST_ACTIVE;  // New aliens enter alive.
        spawn_rec.spare = '0;
    end

    //////////////////////////////
    // Per-slot update.
    always_comb begin
        logic       up;
        logic [1:0] step;
        for (int i = 0; i < `OBJ_LIMIT; i++) begin
            slots_next[i] = slots[i];
            up            = 1'b1;
            step          = 2'd1;
            case (slots[i].state)
                ST_ACTIVE: begin
                    if (tick.move && slots[i].r != '0)
                        slots_next[i].r = slots[i].r - 4'd1;
                    case (slots[i].kind)
                        KIND_0: up = !tick.swing;
                        KIND_1: up = tick.swing;
                        KIND_2: step = tick.odd ? 2'd2 : 2'd1;  // 1.5 times as fast.
                        default: begin
                            up   = 1'b0;
                            step = tick.odd ? 2'd2 : 2'd1;
                        end
                    endcase
                    slots_next[i].theta = theta_step(slots[i].theta, up, step);
                    if (tick.anim)
                        slots_next[i].frame_num[0] = ~slots[i].frame_num[0];
                    if (hit.valid && hit.slot == slot_idx_t'(i)) begin
                        slots_next[i].hp = slots[i].hp - 4'd1;
                        if (hit.kill) begin
                            slots_next[i].state     = ST_DYING;
                            slots_next[i].frame_num = 2'd2;  // First death frame.
                        end
                    end
                end
                ST_DYING: begin
                    if (tick.die) begin
                        if (slots[i].frame_num == 2'd3)
                            slots_next[i] = IDLE_SLOT;
                        else
                            slots_next[i].frame_num = slots[i].frame_num + 2'd1;
                    end
                end
                default: ;
            endcase
            if (spawn_object && free_found && free_idx == slot_idx_t'(i))
                slots_next[i] = spawn_rec;
        end
    end

    always_ff @(posedge clk_frame or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `OBJ_LIMIT; i++)
                slots[i] <= IDLE_SLOT;
        end else if (tick.advance) begin
            slots <= slots_next;
        end
    end

    //////////////////////////////
    // Status flags.
    always_comb begin
        all_clear    = 1'b1;
        game_over    = 1'b0;
        object_count = '0;
        for (int i = 0; i < `OBJ_LIMIT; i++) begin
            if (slots[i].state != ST_INACTIVE)
                all_clear = 1'b0;
            if (slots[i].state == ST_ACTIVE) begin
                object_count = object_count + 4'd1;
                if (slots[i].r == '0)
                    game_over = 1'b1;  // Reached the player.
            end
        end
    end

    // Reported hits only ever land on live aliens.
    assert property (@(posedge clk_frame) disable iff (rst)
        hit.valid |-> slots[hit.slot].state == ST_ACTIVE);

endmodule

//--- hdl/laser_unit.sv
`timescale 1ns/100ps
`include "event_core_cfg.svh"

module laser_unit (
    input  logic                    clk_frame,
    input  logic                    rst,
    input  player_pkg::frame_tick_t tick,
    input  logic                    spawn_laser,
    input  player_pkg::dir_t        dir,
    input  object_pkg::alien_t      slots [`OBJ_LIMIT],
    output player_pkg::laser_t      laser,
    output player_pkg::hit_t        hit,
    output logic [`SCORE_W-1:0]     score
);

    import object_pkg::*;
    import player_pkg::*;

    localparam logic [`SCORE_W-1:0] KILL_POINTS = 100;
    localparam logic [`SCORE_W-1:0] HIT_POINTS  = 10;

    hit_t   found;   // First alien in the beam before gating.
    laser_t shot;
    logic   at_rim;

    // Laser angles sit at 45 + k*90 and the cone never wraps past zero.
    function automatic logic in_cone(input logic [8:0] theta, input logic [8:0] deg);
        logic [8:0] diff;
        diff    = (theta > deg) ? theta - deg : deg - theta;
        in_cone = diff <= 9'(`LSR_WIDTH);
    endfunction

    always_comb begin
        found = '0;
        for (int i = 0; i < `OBJ_LIMIT; i++) begin
            if (!found.valid && slots[i].state == ST_ACTIVE && slots[i].r == laser.r
                && in_cone(slots[i].theta, laser.deg)) begin
                found.valid = 1'b1;
                found.slot  = slot_idx_t'(i);
                found.kill  = slots[i].hp == 4'd1;
            end
        end
    end

    assign at_rim = laser.r == 4'(`R_LIMIT);

    always_comb begin
        hit       = found;
        hit.valid = found.valid && laser.active && tick.advance && !at_rim;
        hit.kill  = found.kill && hit.valid;
    end

    always_comb begin
        shot.active = 1'b1;
        shot.r      = '0;
        shot.deg    = 9'(dir) * 9'd90 + 9'd45;
    end

    always_ff @(posedge clk_frame or posedge rst) begin
        if (rst) begin
            laser <= '0;
            score <= '0;
        end else if (tick.advance) begin
            if (laser.active) begin
                if (at_rim) begin
                    laser.active <= 1'b0;
                end else if (hit.valid) begin
                    laser.active <= 1'b0;
                    score        <= score + (hit.kill ? KILL_POINTS : HIT_POINTS);
                end else begin
                    laser.r <= laser.r + 4'd1;
                end
            end else if (spawn_laser) begin
                laser <= shot;
            end
        end
    end

    // A live beam either steps out by one or retires.
    assert property (@(posedge clk_frame) disable iff (rst)
        (laser.active && tick.advance) |=>
        !laser.active || 5'(laser.r) == 5'($past(laser.r)) + 5'd1);

endmodule

//--- hdl/distance_sorter.sv
`timescale 1ns/100ps
`include "event_core_cfg.svh"

module distance_sorter (
    input  logic               clk_frame,
    input  logic               rst,
    input  object_pkg::alien_t unordered [`OBJ_LIMIT],
    output object_pkg::alien_t ordered   [`OBJ_LIMIT]
);

    import object_pkg::*;

    localparam int N      = `OBJ_LIMIT;
    localparam int LOG_N  = $clog2(N);
    localparam int STAGES = LOG_N * (LOG_N + 1) / 2;

    // Slot index carried on each wire after each stage.
    slot_idx_t perm [STAGES+1][N];

    //////////////////////////////
    // Batcher odd-even merge network, compare-exchange on indices.
    generate
        for (genvar x = 0; x < N; x++) begin : g_seed
            assign perm[0][x] = slot_idx_t'(x);
        end

        for (genvar pl = 0; pl < LOG_N; pl++) begin : g_merge
            for (genvar kd = 0; kd <= pl; kd++) begin : g_step
                localparam int P   = 1 << pl;
                localparam int K   = 1 << (pl - kd);
                localparam int S   = pl * (pl + 1) / 2 + kd;
                localparam int OFS = K % P;
                for (genvar x = 0; x < N; x++) begin : g_wire
                    // Lower end of a pair, both ends in one 2P block.
                    localparam bit LOW = (x >= OFS) && (((x - OFS) % (2 * K)) < K)
                                         && (x + K < N) && ((x / (2 * P)) == ((x + K) / (2 * P)));
                    localparam bit HIGH = (x >= K + OFS) && (((x - K - OFS) % (2 * K)) < K)
                                          && (((x - K) / (2 * P)) == (x / (2 * P)));
                    if (LOW) begin : g_low
                        assign perm[S+1][x] =
                            (unordered[perm[S][x]].r > unordered[perm[S][x+K]].r)
                            ? perm[S][x+K] : perm[S][x];
                    end else if (HIGH) begin : g_high
                        assign perm[S+1][x] =
                            (unordered[perm[S][x-K]].r > unordered[perm[S][x]].r)
                            ? perm[S][x-K] : perm[S][x];
                    end else begin : g_pass
                        assign perm[S+1][x] = perm[S][x];
                    end
                end
            end
        end
    endgenerate

    //////////////////////////////
    // Gather records, one cycle behind the table.
    always_ff @(posedge clk_frame) begin
        for (int i = 0; i < N; i++)
            ordered[i] <= unordered[perm[STAGES][i]];
    end

    generate
        for (genvar x = 0; x + 1 < N; x++) begin : g_check
            assert property (@(posedge clk_frame) disable iff (rst)
                ordered[x].r <= ordered[x+1].r);  // Nearest first.
        end
    endgenerate

endmodule

//--- hdl/event_core.sv
`timescale 1ns/100ps
`include "event_core_cfg.svh"

module event_core (
    input  logic                 clk_frame,
    input  logic                 rst,
    input  logic                 en,
    input  logic                 spawn_laser,
    input  player_pkg::dir_t     dir,
    input  logic                 spawn_object,
    input  object_pkg::alien_t   spawn_data,
    output logic [`SCORE_W-1:0]  score,
    output logic                 all_clear,
    output logic                 game_over,
    output logic [3:0]           object_count,
    output player_pkg::laser_t   laser,
    output object_pkg::alien_t   sorted_aliens [`OBJ_LIMIT]
);

    import object_pkg::*;
    import player_pkg::*;

    frame_tick_t tick;
    hit_t        hit;
    alien_t      slots [`OBJ_LIMIT];

    frame_control frame_control_inst (
        .clk_frame (clk_frame),
        .rst       (rst),
        .en        (en),
        .tick      (tick)
    );

    alien_table alien_table_inst (
        .clk_frame    (clk_frame),
        .rst          (rst),
        .tick         (tick),
        .spawn_object (spawn_object),
        .spawn_data   (spawn_data),
        .hit          (hit),
        .slots        (slots),
        .all_clear    (all_clear),
        .game_over    (game_over),
        .object_count (object_count)
    );

    laser_unit laser_unit_inst (
        .clk_frame   (clk_frame),
        .rst         (rst),
        .tick        (tick),
        .spawn_laser (spawn_laser),
        .dir         (dir),
        .slots       (slots),
        .laser       (laser),
        .hit         (hit),
        .score       (score)
    );

    distance_sorter distance_sorter_inst (
        .clk_frame (clk_frame),
        .rst       (rst),
        .unordered (slots),
        .ordered   (sorted_aliens)
    );

endmodule

//--- verification/event_core_tb.sv
`timescale 1ns/100ps
`include "event_core_cfg.svh"

module event_core_tb;

    import object_pkg::*;
    import player_pkg::*;

    localparam int CLK_PERIOD    = 8;
    localparam int REC_W         = $bits(alien_t);
    localparam int FLIGHT_FRAMES = `R_LIMIT + 3;
    // Resets, spawn phase, five flights, kill phase, game over phase.
    localparam int TEST_FRAMES   = 4 * 8 + 12 * 4 + 5 * FLIGHT_FRAMES + 64
                                   + (1 << `MOVE_BIT) + 48;
    localparam logic [`SCORE_W-1:0] KILL_SCORE = 100;
    localparam logic [`SCORE_W-1:0] HIT_SCORE  = 10;

    logic                clk_frame;
    logic                rst;
    logic                en;
    logic                spawn_laser;
    dir_t                dir;
    logic                spawn_object;
    alien_t              spawn_data;
    logic [`SCORE_W-1:0] score;
    logic                all_clear;
    logic                game_over;
    logic [3:0]          object_count;
    laser_t              laser;
    alien_t              sorted_aliens [`OBJ_LIMIT];

    int   seed;
    int   phase;
    int   frames;  // Mirror of the frame counter.
    int   mismatch_count;
    int   failure_count;
    int   target_hp;
    logic expect_kill;
    logic sorted_ok;
    logic [3:0] sorted_active;
    logic [`OBJ_LIMIT*REC_W-1:0] sorted_flat;

    event_core event_core_inst (
        .clk_frame    (clk_frame),
        .rst          (rst),
        .en           (en),
        .spawn_laser  (spawn_laser),
        .dir          (dir),
        .spawn_object (spawn_object),
        .spawn_data   (spawn_data),
        .score        (score),
        .all_clear    (all_clear),
        .game_over    (game_over),
        .object_count (object_count),
        .laser        (laser),
        .sorted_aliens(sorted_aliens)
    );

    initial begin
        clk_frame = 1'b0;
        forever #(CLK_PERIOD / 2) clk_frame = ~clk_frame;
    end

    always_ff @(posedge clk_frame or posedge rst) begin
        if (rst)
            frames <= 0;
        else if (en)
            frames <= frames + 1;
    end

    always_comb begin
        sorted_ok     = 1'b1;
        sorted_active = '0;
        for (int i = 0; i < `OBJ_LIMIT; i++) begin
            sorted_flat[i*REC_W +: REC_W] = sorted_aliens[i];
            if (sorted_aliens[i].state == ST_ACTIVE)
                sorted_active = sorted_active + 4'd1;
        end
        for (int i = 1; i < `OBJ_LIMIT; i++) begin
            if (sorted_aliens[i].r < sorted_aliens[i-1].r)
                sorted_ok = 1'b0;
        end
    end

    function automatic logic [8:0] beam_angle(input logic [1:0] d);
        case (d)
            2'd0:    beam_angle = 9'd45;
            2'd1:    beam_angle = 9'd135;
            2'd2:    beam_angle = 9'd225;
            default: beam_angle = 9'd315;
        endcase
    endfunction

    task automatic note_mismatch(input string msg);
        mismatch_count++;
        $display("Mismatch at %0t: %s", $time, msg);
    endtask

    task automatic note_failure(input string msg);
        failure_count++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    //////////////////////////////
    // Checks.
    assert property (@(posedge clk_frame) $fell(rst) |-> score == '0 && all_clear
        && !game_over && object_count == '0 && !laser.active)
        else note_mismatch("outputs after reset");
    assert property (@(posedge clk_frame) disable iff (rst)
        (en && spawn_object && all_clear) |=> !all_clear)
        else note_mismatch("all_clear stayed high after a spawn");
    assert property (@(posedge clk_frame) disable iff (rst) (phase == 2 && en) |=>
        object_count == (($past(spawn_object) && $past(object_count) < 4'(`OBJ_LIMIT))
                         ? $past(object_count) + 4'd1 : $past(object_count)))
        else note_mismatch("object_count did not follow the spawn strobes");
    assert property (@(posedge clk_frame) disable iff (rst) sorted_ok)
        else note_mismatch("sorted_aliens out of radius order");
    assert property (@(posedge clk_frame) disable iff (rst)
        sorted_active == $past(object_count))
        else note_mismatch("active entries in sorted_aliens");
    assert property (@(posedge clk_frame) disable iff (rst) (en && spawn_laser && !laser.active)
        |=> laser.active && laser.r == '0 && laser.deg == beam_angle($past(dir)))
        else note_mismatch("laser launch position");
    assert property (@(posedge clk_frame) disable iff (rst)
        (en && laser.active && laser.r == 4'(`R_LIMIT)) |=> !laser.active)
        else note_mismatch("laser still active past the rim");
    assert property (@(posedge clk_frame) disable iff (rst)
        (phase == 4 && en && laser.active && laser.r != 4'(`R_LIMIT)) |=>
        laser.active && laser.r == $past(laser.r) + 4'd1 && laser.deg == $past(laser.deg))
        else note_mismatch("laser flight step");
    // Hit scoring, the rim case is a miss.
    assert property (@(posedge clk_frame) disable iff (rst)
        (phase == 5 && $fell(laser.active) && $past(laser.r) != 4'(`R_LIMIT)) |->
        score == $past(score) + (expect_kill ? KILL_SCORE : HIT_SCORE))
        else note_mismatch("score after a hit");
    assert property (@(posedge clk_frame) disable iff (rst)
        (phase == 5 && expect_kill && $fell(laser.active)) |->
        object_count == $past(object_count) - 4'd1)
        else note_mismatch("object_count after a kill");
    assert property (@(posedge clk_frame) disable iff (rst)
        (phase == 5 && laser.active) |-> laser.r != 4'(`R_LIMIT))
        else note_failure("laser reached the rim without hitting the target");
    assert property (@(posedge clk_frame) disable iff (rst)
        phase == 6 |-> game_over == (frames > (1 << `MOVE_BIT)))
        else note_mismatch("game_over against the move strobe");
    assert property (@(posedge clk_frame) disable iff (rst)
        $past(en) == 1'b0 |-> score == $past(score) && laser == $past(laser))
        else note_mismatch("score or laser changed while en was low");
    assert property (@(posedge clk_frame) disable iff (rst)
        ($past(en) == 1'b0 && $past(en, 2) == 1'b0) |-> sorted_flat == $past(sorted_flat))
        else note_mismatch("sorted_aliens changed while en was low");

    //////////////////////////////
    // Stimulus.
    task automatic apply_reset();
        @(negedge clk_frame);
        rst          = 1'b1;
        en           = 1'b0;
        spawn_laser  = 1'b0;
        spawn_object = 1'b0;
        repeat (4) @(negedge clk_frame);
        rst = 1'b0;
    endtask

    task automatic random_alien(output alien_t a);
        a       = '0;
        a.r     = 4'($random(seed));
        a.theta = 9'($unsigned($random(seed)) % (`ANGLE_MAX + 1));
        a.hp    = 4'($random(seed));
        a.state = ST_ACTIVE;
        a.kind  = alien_kind_t'(2'($random(seed)));
    endtask

    task automatic spawn_alien(input alien_t a);
        @(negedge clk_frame);
        en           = 1'b1;
        spawn_data   = a;
        spawn_object = 1'b1;
        @(negedge clk_frame);
        spawn_object = 1'b0;
    endtask

    task automatic fire_laser(input logic [1:0] d);
        @(negedge clk_frame);
        en          = 1'b1;
        dir         = dir_t'(d);
        spawn_laser = 1'b1;
        @(negedge clk_frame);
        spawn_laser = 1'b0;
    endtask

    task automatic wait_laser_idle();
        int n;
        n = 0;
        while (laser.active && n < FLIGHT_FRAMES) begin
            @(negedge clk_frame);
            n++;
        end
        if (laser.active)
            note_failure("laser did not retire in time");
    endtask

    task automatic wait_all_clear();
        int n;
        n = 0;
        while (!all_clear && n < 40) begin
            @(negedge clk_frame);
            n++;
        end
        if (!all_clear)
            note_failure("all_clear did not return after the death animation");
    endtask

    initial begin
        alien_t rec;
        int     gap;
        seed           = 32'hd503_b085;
        rst            = 1'b1;
        en             = 1'b0;
        spawn_laser    = 1'b0;
        dir            = DIR_45;
        spawn_object   = 1'b0;
        spawn_data     = '0;
        phase          = 1;
        mismatch_count = 0;
        failure_count  = 0;
        target_hp      = 0;
        expect_kill    = 1'b0;
        repeat (4) @(negedge clk_frame);
        rst = 1'b0;
        repeat (3) @(negedge clk_frame);

        phase = 2;  // Fill the table, then overflow it.
        for (int k = 0; k < `OBJ_LIMIT + 3; k++) begin
            random_alien(rec);
            spawn_alien(rec);
            gap = int'($unsigned($random(seed)) % 3);
            repeat (gap) @(negedge clk_frame);
        end
        assert (object_count == 4'(`OBJ_LIMIT)) else note_mismatch("table did not fill");

        apply_reset();
        phase = 4;
        for (int k = 0; k < 4; k++) begin
            fire_laser(2'(k));
            if (k == 1) begin
                repeat (3) @(negedge clk_frame);
                fire_laser(2'd3);  // Dropped, beam already out.
            end
            wait_laser_idle();
        end

        apply_reset();
        phase = 5;
        rec = '{r: 4'd2, theta: 9'd42, hp: 4'd2, state: ST_ACTIVE, kind: KIND_0,
                frame_num: 2'd0, spare: 2'd0};
        target_hp = 2;
        spawn_alien(rec);
        en = 1'b0;
        while (target_hp > 0) begin
            expect_kill = target_hp == 1;
            fire_laser(2'd0);
            wait_laser_idle();
            en = 1'b0;  // Alien holds still between shots.
            target_hp--;
            repeat (4) @(negedge clk_frame);
        end
        en = 1'b1;
        wait_all_clear();

        apply_reset();
        phase = 6;
        rec = '{r: 4'd1, theta: 9'd90, hp: 4'd3, state: ST_ACTIVE, kind: KIND_1,
                frame_num: 2'd0, spare: 2'd0};
        spawn_alien(rec);
        fire_laser(2'd2);
        repeat (5) @(negedge clk_frame);
        en = 1'b0;
        repeat (12) @(negedge clk_frame);
        en = 1'b1;
        while (frames <= (1 << `MOVE_BIT) + 8)
            @(negedge clk_frame);
        assert (game_over) else note_mismatch("game_over low after the move strobe");

        @(negedge clk_frame);
        $display("Checks failed: %0d mismatches, %0d other errors", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(2 * TEST_FRAMES * CLK_PERIOD);
        $display("Watchdog expired after %0d frames, run did not finish", 2 * TEST_FRAMES);
        $display("Checks failed: %0d mismatches, %0d other errors", mismatch_count,
                 failure_count + 1);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- files.f
+incdir+include
hdl/object_pkg.sv
hdl/player_pkg.sv
hdl/frame_control.sv
hdl/alien_table.sv
hdl/laser_unit.sv
hdl/distance_sorter.sv
hdl/event_core.sv
verification/event_core_tb.sv

//--- Makefile
# Verilator build and run of the event core testbench.
VERILATOR ?= verilator
TOP       ?= event_core_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, fail unless the run passes"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf $(OBJ_DIR)
